/* robot_follow.f */
hw/robot_follow_pkg.sv
hw/ir_nec_receiver.sv
hw/range_averager.sv
hw/target_locator.sv
hw/follow_cfg_regs.sv
hw/drive_logic.sv
hw/robot_follow.sv
dv/robot_follow_chk.sv
dv/robot_follow_tb.sv

/* dv/robot_follow_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module robot_follow_tb;

	localparam int          UNIT       = 4;
	localparam logic [15:0] ADDR       = 16'h6b86;
	localparam int          MARGIN     = 4;
	// leader, 32 long bits, stop burst, idle gap
	localparam int          FRAME_CLKS = (16 + 8 + 32 * 4 + 1 + 10) * UNIT;
	localparam int          ROW_CLKS   = 200;
	localparam int          N_RAND     = 6;
	// marks rows whose expected values come from the model only
	localparam logic [2:0]  EXP_MODEL  = 3'd7;

	localparam logic [7:0] NONE = 8'h00;
	localparam logic [7:0] STOP = robot_follow_pkg::IR_CMD_STOP;
	localparam logic [7:0] GO   = robot_follow_pkg::IR_CMD_GO;
	localparam logic [7:0] FAR  = robot_follow_pkg::IR_CMD_FAR;
	localparam logic [7:0] NEAR = robot_follow_pkg::IR_CMD_NEAR;

	localparam logic [2:0] C_STOP = robot_follow_pkg::stop;
	localparam logic [2:0] C_FL   = robot_follow_pkg::fast_left;
	localparam logic [2:0] C_L    = robot_follow_pkg::left;
	localparam logic [2:0] C_ST   = robot_follow_pkg::straight;
	localparam logic [2:0] C_R    = robot_follow_pkg::right;
	localparam logic [2:0] C_FR   = robot_follow_pkg::fast_right;

	typedef struct packed {
		logic [7:0] ir_cmd;
		logic [3:0] ir_cnt;
		logic       corrupt;
		logic       bad_addr;
		logic       red;
		logic [4:0] lo;
		logic [4:0] hi;
		logic [7:0] rng;
		logic       wr;
		logic [7:0] lb;
		logic [7:0] rb;
		logic [2:0] exp_cmd;
		logic [7:0] exp_fd;
	} row_t;

	logic                         clk;
	logic                         rst_n;
	logic                         ir_rx;
	logic                         cam_red;
	logic                         cam_valid;
	logic                         cam_line_end;
	logic [7:0]                   range_sample;
	logic                         range_valid;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	logic [1:0]                   wb_adr;
	logic [7:0]                   wb_dat_w;
	logic [15:0]                  wb_dat_r;
	logic                         wb_ack;
	robot_follow_pkg::drive_cmd_e drive_command;
	logic [7:0]                   follow_distance;

	row_t        rows[$];
	string       names[$];
	logic        table_ready;
	int          errors;
	logic [31:0] rand_state;

	// reference model state
	logic       m_bot_off;
	logic       m_no_red;
	logic [7:0] m_fd;
	logic [7:0] m_avg;
	int         m_dir;
	int         m_left;
	int         m_right;

	robot_follow #(
		.CLKS_PER_UNIT (UNIT)
	) u_robot_follow (
		.clk             (clk),
		.rst_n           (rst_n),
		.ir_rx           (ir_rx),
		.cam_red         (cam_red),
		.cam_valid       (cam_valid),
		.cam_line_end    (cam_line_end),
		.range_sample    (range_sample),
		.range_valid     (range_valid),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack),
		.drive_command   (drive_command),
		.follow_distance (follow_distance)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// steering priority, stop conditions first
	function automatic logic [2:0] steer_rule(input logic off, input logic nored,
		input logic [7:0] avg, input logic [7:0] fd, input int dir, input int lb, input int rb);
		if (off || nored || (avg < fd))
			return C_STOP;
		if (dir + MARGIN < lb)
			return C_FL;
		if (dir < lb)
			return C_L;
		if (dir > rb + MARGIN)
			return C_FR;
		if (dir > rb)
			return C_R;
		return C_ST;
	endfunction

	// far/near step with saturation
	function automatic logic [7:0] step_distance(input logic [7:0] fd, input logic [7:0] cmd);
		int d;
		d = fd;
		if (cmd == FAR)
			d = d + robot_follow_pkg::FOLLOW_STEP;
		else if (cmd == NEAR)
			d = d - robot_follow_pkg::FOLLOW_STEP;
		if (d > robot_follow_pkg::FOLLOW_MAX)
			d = robot_follow_pkg::FOLLOW_MAX;
		if (d < robot_follow_pkg::FOLLOW_MIN)
			d = robot_follow_pkg::FOLLOW_MIN;
		return 8'(d);
	endfunction

	task automatic add_row(input string name, input logic [7:0] cmd, input int cnt, corrupt,
		bad_addr, red, lo, hi, rng, wr, lb, rb, input logic [2:0] exp_cmd, input int exp_fd);
		row_t r;
		r.ir_cmd = cmd;
		r.ir_cnt = 4'(cnt);
		r.corrupt = 1'(corrupt);
		r.bad_addr = 1'(bad_addr);
		r.red = 1'(red);
		r.lo = 5'(lo);
		r.hi = 5'(hi);
		r.rng = 8'(rng);
		r.wr = 1'(wr);
		r.lb = 8'(lb);
		r.rb = 8'(rb);
		r.exp_cmd = exp_cmd;
		r.exp_fd = 8'(exp_fd);
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		int lo;
		int hi;
		//       name           ir    n  cor bad red lo hi  rng wr  lb  rb  cmd    fd
		add_row("reset",        NONE, 0, 0, 0, 0, 0,  0,  255, 0, 0,  0,  C_STOP, 20);
		add_row("go_straight",  GO,   1, 0, 0, 1, 10, 13, 200, 0, 0,  0,  C_ST,   20);
		add_row("left",         NONE, 0, 0, 0, 1, 5,  7,  200, 0, 0,  0,  C_L,    20);
		add_row("fast_left",    NONE, 0, 0, 0, 1, 0,  4,  200, 0, 0,  0,  C_FL,   20);
		add_row("right",        NONE, 0, 0, 0, 1, 16, 18, 200, 0, 0,  0,  C_R,    20);
		add_row("fast_right",   NONE, 0, 0, 0, 1, 20, 24, 200, 0, 0,  0,  C_FR,   20);
		add_row("too_close",    NONE, 0, 0, 0, 1, 10, 13, 15,  0, 0,  0,  C_STOP, 20);
		add_row("no_red",       NONE, 0, 0, 0, 0, 0,  0,  200, 0, 0,  0,  C_STOP, 20);
		add_row("stop_button",  STOP, 1, 0, 0, 1, 10, 13, 200, 0, 0,  0,  C_STOP, 20);
		add_row("go_again",     GO,   1, 0, 0, 1, 10, 13, 200, 0, 0,  0,  C_ST,   20);
		add_row("far_flip",     FAR,  1, 0, 0, 1, 10, 13, 25,  0, 0,  0,  C_STOP, 30);
		add_row("near_flip",    NEAR, 1, 0, 0, 1, 10, 13, 25,  0, 0,  0,  C_ST,   20);
		add_row("far_sat",      FAR,  9, 0, 0, 1, 10, 13, 200, 0, 0,  0,  C_ST,   100);
		add_row("far_close",    FAR,  1, 0, 0, 1, 10, 13, 95,  0, 0,  0,  C_STOP, 100);
		add_row("near_sat",     NEAR, 9, 0, 0, 1, 10, 13, 95,  0, 0,  0,  C_ST,   20);
		add_row("corrupt_far",  FAR,  1, 1, 0, 1, 10, 13, 25,  0, 0,  0,  C_ST,   20);
		add_row("wrong_addr",   STOP, 1, 0, 1, 1, 10, 13, 200, 0, 0,  0,  C_ST,   20);
		add_row("bounds_left",  NONE, 0, 0, 0, 1, 10, 13, 200, 1, 12, 18, C_L,    20);
		add_row("bounds_fast",  NONE, 0, 0, 0, 1, 10, 13, 200, 1, 16, 20, C_FL,   20);
		add_row("bounds_right", NONE, 0, 0, 0, 1, 10, 13, 200, 1, 2,  6,  C_FR,   20);
		add_row("bounds_back",  NONE, 0, 0, 0, 1, 10, 13, 200, 1, 8,  15, C_ST,   20);
		// random spans under the default bounds
		for (int k = 0; k < N_RAND; k++) begin
			rand_state = lcg_next(rand_state);
			lo = int'(rand_state[23:16]) % 25;
			rand_state = lcg_next(rand_state);
			hi = lo + int'(rand_state[23:16]) % 6;
			if (hi > 24)
				hi = 24;
			add_row($sformatf("random_%0d", k), NONE, 0, 0, 0, 1, lo, hi, 200, 0, 0, 0,
				EXP_MODEL, 0);
		end
	endtask

	// hold one level for a number of NEC units
	task automatic ir_level(input logic lvl, input int units);
		ir_rx = lvl;
		repeat (units * UNIT) @(negedge clk);
	endtask

	task automatic send_ir(input logic [15:0] addr, input logic [7:0] cmd, input logic corrupt);
		logic [31:0] word;
		// inverse byte on top, bit 0 of it flipped when corrupt
		word = {~cmd ^ {7'b0, corrupt}, cmd, addr};
		@(negedge clk);
		ir_level(1'b0, 16);
		ir_level(1'b1, 8);
		for (int i = 0; i < 32; i++) begin
			ir_level(1'b0, 1);
			ir_level(1'b1, word[i] ? 3 : 1);
		end
		// stop burst, then idle gap
		ir_level(1'b0, 1);
		ir_level(1'b1, 10);
	endtask

	task automatic send_line(input logic red, input int lo, input int hi);
		for (int c = 0; c < 25; c++) begin
			@(negedge clk);
			cam_valid = 1'b1;
			cam_red = red && (c >= lo) && (c <= hi);
		end
		@(negedge clk);
		cam_valid = 1'b0;
		cam_red = 1'b0;
		cam_line_end = 1'b1;
		@(negedge clk);
		cam_line_end = 1'b0;
	endtask

	// four equal samples fill the whole average window
	task automatic send_range(input logic [7:0] value);
		repeat (4) begin
			@(negedge clk);
			range_sample = value;
			range_valid = 1'b1;
		end
		@(negedge clk);
		range_valid = 1'b0;
	endtask

	task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
		output logic [15:0] rdata);
		int wait_cnt;
		rdata = 'x;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		@(negedge clk);
		wait_cnt = 1;
		while (!wb_ack && wait_cnt < 16) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (wb_ack) begin
			rdata = wb_dat_r;
		end else begin
			errors++;
			$display("wishbone cycle to address %0d got no ack in 16 cycles", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic report_mismatch(input string test, input string field,
		input logic [15:0] exp, input logic [15:0] act);
		errors++;
		$display("[ERROR] %s %s expected %0h actual %0h", test, field, exp, act);
	endtask

	// drive one row and move the model along with it
	task automatic apply_row(input row_t r);
		logic [15:0] dummy;
		if (r.ir_cmd != NONE) begin
			for (int k = 0; k < r.ir_cnt; k++) begin
				send_ir(r.bad_addr ? ~ADDR : ADDR, r.ir_cmd, r.corrupt);
				if (!r.corrupt && !r.bad_addr) begin
					if (r.ir_cmd == STOP)
						m_bot_off = 1'b1;
					if (r.ir_cmd == GO)
						m_bot_off = 1'b0;
					m_fd = step_distance(m_fd, r.ir_cmd);
				end
			end
		end
		if (r.wr) begin
			wb_cycle(1'b1, robot_follow_pkg::REG_LEFT, r.lb, dummy);
			wb_cycle(1'b1, robot_follow_pkg::REG_RIGHT, r.rb, dummy);
			m_left = r.lb;
			m_right = r.rb;
		end
		send_range(r.rng);
		m_avg = r.rng;
		send_line(r.red, r.lo, r.hi);
		// blank line keeps the old heading
		if (r.red)
			m_dir = (int'(r.lo) + int'(r.hi)) / 2;
		m_no_red = !r.red;
	endtask

	// watchdog sized from the table, frames dominate
	initial begin
		int budget;
		wait (table_ready);
		budget = 40;
		foreach (rows[i])
			budget += ((rows[i].ir_cnt > 0) ? int'(rows[i].ir_cnt) : 1) * (FRAME_CLKS + ROW_CLKS);
		repeat (budget) @(posedge clk);
		$display("timeout: scenario loop still running after %0d cycles", budget);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic [15:0] st;
		logic [15:0] rd;
		logic [2:0]  exp_cmd;
		clk = 1'b0;
		rst_n = 1'b0;
		ir_rx = 1'b1;
		cam_red = 1'b0;
		cam_valid = 1'b0;
		cam_line_end = 1'b0;
		range_sample = 8'h00;
		range_valid = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 8'h00;
		errors = 0;
		rand_state = 32'h70c9_273b;
		table_ready = 1'b0;
		m_bot_off = 1'b1;
		m_no_red = 1'b1;
		m_fd = 8'd20;
		m_avg = 8'hff;
		m_dir = 12;
		m_left = 8;
		m_right = 15;
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (rows[i]) begin
			apply_row(rows[i]);
			exp_cmd = steer_rule(m_bot_off, m_no_red, m_avg, m_fd, m_dir, m_left, m_right);
			// hand written rows must agree with the rule model
			if (rows[i].exp_cmd != EXP_MODEL) begin
				if (rows[i].exp_cmd != exp_cmd || rows[i].exp_fd != m_fd) begin
					errors++;
					$display("table row %s disagrees with the steering rules", names[i]);
				end
			end
			repeat (20) @(negedge clk);
			wb_cycle(1'b0, robot_follow_pkg::REG_STATUS, 8'h00, st);
			if (st[15:13] !== exp_cmd)
				report_mismatch(names[i], "status.drive_command", exp_cmd, st[15:13]);
			if (st[12] !== m_bot_off)
				report_mismatch(names[i], "status.bot_off", m_bot_off, st[12]);
			if (st[11] !== m_no_red)
				report_mismatch(names[i], "status.no_red", m_no_red, st[11]);
			if (st[10:8] !== 3'b000)
				report_mismatch(names[i], "status.spare", 3'b000, st[10:8]);
			if (st[7:0] !== m_fd)
				report_mismatch(names[i], "status.follow_distance", m_fd, st[7:0]);
			if (3'(drive_command) !== exp_cmd)
				report_mismatch(names[i], "drive_command", exp_cmd, 3'(drive_command));
			if (follow_distance !== m_fd)
				report_mismatch(names[i], "follow_distance", m_fd, follow_distance);
			// bounds read back as written
			if (rows[i].wr) begin
				wb_cycle(1'b0, robot_follow_pkg::REG_LEFT, 8'h00, rd);
				if (rd !== 16'(rows[i].lb))
					report_mismatch(names[i], "left_bound", 16'(rows[i].lb), rd);
				wb_cycle(1'b0, robot_follow_pkg::REG_RIGHT, 8'h00, rd);
				if (rd !== 16'(rows[i].rb))
					report_mismatch(names[i], "right_bound", 16'(rows[i].rb), rd);
			end
		end
		$display("rows: %0d  errors: %0d", rows.size(), errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/robot_follow_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module robot_follow_chk (
	input wire       clk,
	input wire       rst_n,
	input wire       wb_ack,
	input wire [2:0] drive_command,
	input wire [7:0] follow_distance
);

	// one ack per strobe, never back to back
	ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high on two cycles running");

	// only the six drive codes, no x
	cmd_legal: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(drive_command) && (drive_command <= 3'd5))
		else $error("drive_command outside the six legal codes");

	// saturation of the remote steps
	distance_range: assert property (@(posedge clk) disable iff (!rst_n)
		(follow_distance >= robot_follow_pkg::FOLLOW_MIN) &&
		(follow_distance <= robot_follow_pkg::FOLLOW_MAX))
		else $error("follow_distance left its allowed range");

endmodule

// checker rides along with every robot_follow instance
bind robot_follow robot_follow_chk u_robot_follow_chk (
	.clk             (clk),
	.rst_n           (rst_n),
	.wb_ack          (wb_ack),
	.drive_command   (drive_command),
	.follow_distance (follow_distance)
);

`default_nettype wire

/* hw/robot_follow.sv */
`timescale 1ns/1ns
`default_nettype none

module robot_follow #(
	parameter int          FOV                 = 25,
	parameter int          CLKS_PER_UNIT       = 28125,
	parameter logic [15:0] REMOTE_ADDR         = 16'h6b86,
	parameter int          DEFAULT_DISTANCE    = 20,
	parameter int          DEFAULT_LEFT_BOUND  = 8,
	parameter int          DEFAULT_RIGHT_BOUND = 15,
	parameter int          TURN_MARGIN         = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          ir_rx,
	input  wire                          cam_red,
	input  wire                          cam_valid,
	input  wire                          cam_line_end,
	input  wire  [7:0]                   range_sample,
	input  wire                          range_valid,
	input  wire                          wb_cyc,
	input  wire                          wb_stb,
	input  wire                          wb_we,
	input  wire  [1:0]                   wb_adr,
	input  wire  [7:0]                   wb_dat_w,
	output logic [15:0]                  wb_dat_r,
	output logic                         wb_ack,
	output robot_follow_pkg::drive_cmd_e drive_command,
	output logic [7:0]                   follow_distance
);

	// column index needs room for FOV itself
	localparam int DIR_W = $clog2(FOV) + 1;

	robot_follow_pkg::ir_frame_u ir_frame;
	logic                        ir_data_ready;
	logic [7:0]                  average_distance;
	logic [DIR_W-1:0]            detected_direction;
	logic                        no_red;
	logic [DIR_W-1:0]            left_bound;
	logic [DIR_W-1:0]            right_bound;
	logic                        bot_off;

	// remote decoder
	ir_nec_receiver #(
		.CLKS_PER_UNIT (CLKS_PER_UNIT),
		.REMOTE_ADDR   (REMOTE_ADDR)
	) u_ir_nec_receiver (
		.clk           (clk),
		.rst_n         (rst_n),
		.ir_rx         (ir_rx),
		.ir_frame      (ir_frame),
		.ir_data_ready (ir_data_ready)
	);

	// ultrasonic smoothing
	range_averager u_range_averager (
		.clk              (clk),
		.rst_n            (rst_n),
		.range_sample     (range_sample),
		.range_valid      (range_valid),
		.average_distance (average_distance)
	);

	// red target position per camera line
	target_locator #(
		.FOV   (FOV),
		.DIR_W (DIR_W)
	) u_target_locator (
		.clk                (clk),
		.rst_n              (rst_n),
		.cam_red            (cam_red),
		.cam_valid          (cam_valid),
		.cam_line_end       (cam_line_end),
		.detected_direction (detected_direction),
		.no_red             (no_red)
	);

	// host registers
	follow_cfg_regs #(
		.DIR_W               (DIR_W),
		.DEFAULT_LEFT_BOUND  (DEFAULT_LEFT_BOUND),
		.DEFAULT_RIGHT_BOUND (DEFAULT_RIGHT_BOUND)
	) u_follow_cfg_regs (
		.clk             (clk),
		.rst_n           (rst_n),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack),
		.drive_command   (drive_command),
		.follow_distance (follow_distance),
		.bot_off         (bot_off),
		.no_red          (no_red),
		.left_bound      (left_bound),
		.right_bound     (right_bound)
	);

	// steering decision
	drive_logic #(
		.DIR_W            (DIR_W),
		.DEFAULT_DISTANCE (DEFAULT_DISTANCE),
		.TURN_MARGIN      (TURN_MARGIN)
	) u_drive_logic (
		.clk                (clk),
		.rst_n              (rst_n),
		.no_red             (no_red),
		.detected_direction (detected_direction),
		.average_distance   (average_distance),
		.ir_frame           (ir_frame),
		.ir_data_ready      (ir_data_ready),
		.left_bound         (left_bound),
		.right_bound        (right_bound),
		.drive_command      (drive_command),
		.follow_distance    (follow_distance),
		.bot_off            (bot_off)
	);

endmodule

`default_nettype wire

/* hw/drive_logic.sv */
`timescale 1ns/1ns
`default_nettype none

module drive_logic #(
	parameter int DIR_W            = 6,
	parameter int DEFAULT_DISTANCE = 20,
	parameter int TURN_MARGIN      = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          no_red,
	input  wire  [DIR_W-1:0]             detected_direction,
	input  wire  [7:0]                   average_distance,
	input  wire robot_follow_pkg::ir_frame_u ir_frame,
	input  wire                          ir_data_ready,
	input  wire  [DIR_W-1:0]             left_bound,
	input  wire  [DIR_W-1:0]             right_bound,
	output robot_follow_pkg::drive_cmd_e drive_command,
	output logic [7:0]                   follow_distance,
	output logic                         bot_off
);

	// extra bit so margin sums cannot wrap
	localparam logic [DIR_W:0] MARGIN = (DIR_W + 1)'(TURN_MARGIN);

	robot_follow_pkg::drive_cmd_e next_state;
	robot_follow_pkg::drive_cmd_e current_state;
	logic                         too_close;
	logic [7:0]                   far_distance;
	logic [7:0]                   near_distance;
	logic [DIR_W:0]               dir_ext;

	// follow distance steps clamped at the ends
	assign far_distance = (follow_distance >= robot_follow_pkg::FOLLOW_MAX -
		robot_follow_pkg::FOLLOW_STEP) ? robot_follow_pkg::FOLLOW_MAX :
		follow_distance + robot_follow_pkg::FOLLOW_STEP;
	assign near_distance = (follow_distance <= robot_follow_pkg::FOLLOW_MIN +
		robot_follow_pkg::FOLLOW_STEP) ? robot_follow_pkg::FOLLOW_MIN :
		follow_distance - robot_follow_pkg::FOLLOW_STEP;

	assign dir_ext = {1'b0, detected_direction};

	assign drive_command = current_state;

	// remote buttons
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bot_off <= 1'b1;
			follow_distance <= 8'(DEFAULT_DISTANCE);
		end else if (ir_data_ready) begin
			case (ir_frame.fields.command)
				robot_follow_pkg::IR_CMD_STOP: bot_off <= 1'b1;
				robot_follow_pkg::IR_CMD_GO:   bot_off <= 1'b0;
				robot_follow_pkg::IR_CMD_FAR:  follow_distance <= far_distance;
				robot_follow_pkg::IR_CMD_NEAR: follow_distance <= near_distance;
				// other buttons do nothing
				default: ;
			endcase
		end
	end

	// three stage steering through too_close then next then current
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			too_close <= 1'b0;
			next_state <= robot_follow_pkg::stop;
			current_state <= robot_follow_pkg::stop;
		end else begin
			too_close <= average_distance < follow_distance;
			current_state <= next_state;
			if (no_red || too_close || bot_off)
				next_state <= robot_follow_pkg::stop;
			else if (dir_ext + MARGIN < {1'b0, left_bound})
				next_state <= robot_follow_pkg::fast_left;
			else if (detected_direction < left_bound)
				next_state <= robot_follow_pkg::left;
			else if (dir_ext > {1'b0, right_bound} + MARGIN)
				next_state <= robot_follow_pkg::fast_right;
			else if (detected_direction > right_bound)
				next_state <= robot_follow_pkg::right;
			else
				next_state <= robot_follow_pkg::straight;
		end
	end

endmodule

`default_nettype wire

/* hw/follow_cfg_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module follow_cfg_regs #(
	parameter int DIR_W               = 6,
	parameter int DEFAULT_LEFT_BOUND  = 8,
	parameter int DEFAULT_RIGHT_BOUND = 15
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          wb_cyc,
	input  wire                          wb_stb,
	input  wire                          wb_we,
	input  wire  [1:0]                   wb_adr,
	input  wire  [7:0]                   wb_dat_w,
	output logic [15:0]                  wb_dat_r,
	output logic                         wb_ack,
	input  wire robot_follow_pkg::drive_cmd_e drive_command,
	input  wire  [7:0]                   follow_distance,
	input  wire                          bot_off,
	input  wire                          no_red,
	output logic [DIR_W-1:0]             left_bound,
	output logic [DIR_W-1:0]             right_bound
);

	logic        wb_req;
	logic        wb_held_q;
	logic [15:0] status_word;

	// only a fresh strobe is acked, a held one gets no second ack
	assign wb_req = wb_cyc && wb_stb && !wb_held_q;

	// command, off, no red, three spare bits, distance
	assign status_word = {drive_command, bot_off, no_red, 3'b000, follow_distance};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			wb_held_q <= 1'b0;
			left_bound <= DIR_W'(DEFAULT_LEFT_BOUND);
			right_bound <= DIR_W'(DEFAULT_RIGHT_BOUND);
		end else begin
			wb_ack <= wb_req;
			// strobe seen on the previous clock
			wb_held_q <= wb_cyc && wb_stb;
			if (wb_req && wb_we) begin
				case (wb_adr)
					robot_follow_pkg::REG_LEFT:  left_bound <= wb_dat_w[DIR_W-1:0];
					robot_follow_pkg::REG_RIGHT: right_bound <= wb_dat_w[DIR_W-1:0];
					// status is read only so a write just acks
					default: ;
				endcase
			end
		end
	end

	// read mux sampled with the ack
	always_ff @(posedge clk) begin
		if (wb_req) begin
			case (wb_adr)
				robot_follow_pkg::REG_LEFT:   wb_dat_r <= 16'(left_bound);
				robot_follow_pkg::REG_RIGHT:  wb_dat_r <= 16'(right_bound);
				robot_follow_pkg::REG_STATUS: wb_dat_r <= status_word;
				default:                      wb_dat_r <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/target_locator.sv */
`timescale 1ns/1ns
`default_nettype none

module target_locator #(
	parameter int FOV   = 25,
	parameter int DIR_W = $clog2(FOV) + 1
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              cam_red,
	input  wire              cam_valid,
	input  wire              cam_line_end,
	output logic [DIR_W-1:0] detected_direction,
	output logic             no_red
);

	logic [DIR_W-1:0] col_q;
	logic [DIR_W-1:0] first_q;
	logic [DIR_W-1:0] last_q;
	logic             seen_q;
	logic             red_hit;
	logic [DIR_W:0]   span_sum;

	// red pixel inside the field of view
	assign red_hit = cam_valid && cam_red && (col_q < FOV);

	// one extra bit so the halving is exact
	assign span_sum = {1'b0, first_q} + {1'b0, last_q};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col_q <= '0;
			seen_q <= 1'b0;
			no_red <= 1'b1;
			detected_direction <= DIR_W'(FOV / 2);
		end else if (cam_line_end) begin
			col_q <= '0;
			seen_q <= 1'b0;
			no_red <= !seen_q;
			// blank line keeps the last heading
			if (seen_q)
				detected_direction <= span_sum[DIR_W:1];
		end else if (cam_valid) begin
			col_q <= col_q + 1'b1;
			if (red_hit)
				seen_q <= 1'b1;
		end
	end

	// first and last red column on this line
	always_ff @(posedge clk) begin
		if (red_hit) begin
			if (!seen_q)
				first_q <= col_q;
			last_q <= col_q;
		end
	end

endmodule

`default_nettype wire

/* hw/range_averager.sv */
`timescale 1ns/1ns
`default_nettype none

module range_averager (
	input  wire        clk,
	input  wire        rst_n,
	input  wire  [7:0] range_sample,
	input  wire        range_valid,
	output logic [7:0] average_distance
);

	logic [7:0] hist_q [4];
	logic [9:0] sum_q;

	// sum of four, drop two bits for the mean
	assign average_distance = sum_q[9:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// far away until real samples arrive
			for (int i = 0; i < 4; i++)
				hist_q[i] <= 8'hff;
			sum_q <= 10'd1020;
		end else if (range_valid) begin
			hist_q[0] <= range_sample;
			for (int i = 1; i < 4; i++)
				hist_q[i] <= hist_q[i-1];
			// add newest, retire oldest
			sum_q <= sum_q + 10'(range_sample) - 10'(hist_q[3]);
		end
	end

endmodule

`default_nettype wire

/* hw/ir_nec_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module ir_nec_receiver #(
	parameter int          CLKS_PER_UNIT = 28125,
	parameter logic [15:0] REMOTE_ADDR   = 16'h6b86
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        ir_rx,
	output robot_follow_pkg::ir_frame_u ir_frame,
	output logic                       ir_data_ready
);

	// leader windows, 16 low and 8 high with two units slack
	localparam int LDR_LO_MIN = 14 * CLKS_PER_UNIT;
	localparam int LDR_LO_MAX = 18 * CLKS_PER_UNIT;
	localparam int LDR_HI_MIN = 6 * CLKS_PER_UNIT;
	localparam int LDR_HI_MAX = 10 * CLKS_PER_UNIT;
	// bit slots, a zero high ends below BIT_MAX
	localparam int BIT_MIN = CLKS_PER_UNIT / 2;
	localparam int BIT_MAX = 2 * CLKS_PER_UNIT;
	localparam int ONE_MAX = 4 * CLKS_PER_UNIT;
	localparam int CNT_W   = $clog2(LDR_LO_MAX + 2);

	typedef enum logic [2:0] {
		idle,
		leader_low,
		leader_high,
		bit_low,
		bit_high,
		check
	} rx_state_e;

	rx_state_e                   state_q;
	logic [1:0]                  sync_q;
	logic                        rx;
	logic [CNT_W-1:0]            cnt_q;
	logic [5:0]                  bit_cnt_q;
	logic                        bit_done;
	logic                        frame_ok;
	robot_follow_pkg::ir_frame_u shift_q;

	// line after the synchroniser
	assign rx = sync_q[1];

	// high slot closed with a legal width
	assign bit_done = (state_q == bit_high) && !rx && (cnt_q >= BIT_MIN) && (cnt_q <= ONE_MAX);

	// inverse byte must match and the address must be ours
	assign frame_ok = (shift_q.fields.command_inv == ~shift_q.fields.command) &&
		(shift_q.fields.address == REMOTE_ADDR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q <= 2'b11;
			state_q <= idle;
			cnt_q <= '0;
			bit_cnt_q <= '0;
			ir_data_ready <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], ir_rx};
			ir_data_ready <= 1'b0;
			// width of the current level, restarted at each edge
			cnt_q <= cnt_q + 1'b1;
			case (state_q)
				idle: begin
					cnt_q <= CNT_W'(1);
					if (!rx)
						state_q <= leader_low;
				end
				leader_low: begin
					if (rx) begin
						cnt_q <= CNT_W'(1);
						state_q <= (cnt_q >= LDR_LO_MIN) ? leader_high : idle;
					end else if (cnt_q > LDR_LO_MAX) begin
						state_q <= idle;
					end
				end
				leader_high: begin
					// repeat codes have a short high and fall out here
					if (!rx) begin
						cnt_q <= CNT_W'(1);
						bit_cnt_q <= '0;
						state_q <= (cnt_q >= LDR_HI_MIN) ? bit_low : idle;
					end else if (cnt_q > LDR_HI_MAX) begin
						state_q <= idle;
					end
				end
				bit_low: begin
					if (rx) begin
						cnt_q <= CNT_W'(1);
						if (cnt_q < BIT_MIN)
							state_q <= idle;
						else if (bit_cnt_q == 6'd32)
							// burst after the last bit is the stop bit
							state_q <= check;
						else
							state_q <= bit_high;
					end else if (cnt_q > BIT_MAX) begin
						state_q <= idle;
					end
				end
				bit_high: begin
					if (!rx) begin
						cnt_q <= CNT_W'(1);
						state_q <= bit_done ? bit_low : idle;
						if (bit_done)
							bit_cnt_q <= bit_cnt_q + 1'b1;
					end else if (cnt_q > ONE_MAX) begin
						state_q <= idle;
					end
				end
				check: begin
					ir_data_ready <= frame_ok;
					state_q <= idle;
				end
				default: state_q <= idle;
			endcase
		end
	end

	// lsb first, long high is a one
	always_ff @(posedge clk) begin
		if (bit_done)
			shift_q.raw <= {cnt_q >= BIT_MAX, shift_q.raw[31:1]};
		if (state_q == check)
			ir_frame <= shift_q;
	end

endmodule

`default_nettype wire

/* hw/robot_follow_pkg.sv */
`default_nettype none

package robot_follow_pkg;

	// steering outputs, encoding fixed by the motor side
	typedef enum logic [2:0] {
		stop       = 3'd0,
		fast_left  = 3'd1,
		left       = 3'd2,
		straight   = 3'd3,
		right      = 3'd4,
		fast_right = 3'd5
	} drive_cmd_e;

	// one NEC word, raw or split into its fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [7:0]  command_inv;
			logic [7:0]  command;
			logic [15:0] address;
		} fields;
	} ir_frame_u;

	// remote button codes
	localparam logic [7:0] IR_CMD_STOP = 8'h12;
	localparam logic [7:0] IR_CMD_GO   = 8'h16;
	localparam logic [7:0] IR_CMD_FAR  = 8'h1a;
	localparam logic [7:0] IR_CMD_NEAR = 8'h1e;

	// follow distance range and step
	localparam logic [7:0] FOLLOW_MIN  = 8'd20;
	localparam logic [7:0] FOLLOW_MAX  = 8'd100;
	localparam logic [7:0] FOLLOW_STEP = 8'd10;

	// wishbone word addresses
	localparam logic [1:0] REG_LEFT   = 2'd0;
	localparam logic [1:0] REG_RIGHT  = 2'd1;
	localparam logic [1:0] REG_STATUS = 2'd2;

endpackage

`default_nettype wire
